// ==== logic/shell_volley_defines.svh ====
`ifndef SHELL_VOLLEY_DEFINES_SVH
`define SHELL_VOLLEY_DEFINES_SVH

// ***********************************************************
// field widths
// ***********************************************************
`define SV_COORD_W      10
`define SV_SCORE_W      8
`define SV_ANGLE_W      4
`define SV_STATE_W      7
`define SV_NUM_ANGLES   8

// one-hot game states of which only idle and play matter here
`define SV_STATE_IDLE   7'b0000001
`define SV_STATE_PLAY   7'b0001000

// ***********************************************************
// per-angle flight constants
// ***********************************************************
// launch point, signed step per tick, end axis and edge value
`define SV_A1_X0        890
`define SV_A1_Y0        170
`define SV_A1_DX        (-2)
`define SV_A1_DY        1
`define SV_A1_AXIS      shell_volley_pkg::AXIS_X
`define SV_A1_EDGE      100

`define SV_A2_X0        680
`define SV_A2_Y0        90
`define SV_A2_DX        (-1)
`define SV_A2_DY        2
`define SV_A2_AXIS      shell_volley_pkg::AXIS_Y
`define SV_A2_EDGE      630

`define SV_A3_X0        300
`define SV_A3_Y0        90
`define SV_A3_DX        1
`define SV_A3_DY        2
`define SV_A3_AXIS      shell_volley_pkg::AXIS_Y
`define SV_A3_EDGE      630

`define SV_A4_X0        100
`define SV_A4_Y0        160
`define SV_A4_DX        2
`define SV_A4_DY        1
`define SV_A4_AXIS      shell_volley_pkg::AXIS_X
`define SV_A4_EDGE      890

// angle 5 ends on the right edge like angle 4
`define SV_A5_X0        100
`define SV_A5_Y0        530
`define SV_A5_DX        2
`define SV_A5_DY        (-1)
`define SV_A5_AXIS      shell_volley_pkg::AXIS_X
`define SV_A5_EDGE      890

`define SV_A6_X0        300
`define SV_A6_Y0        630
`define SV_A6_DX        1
`define SV_A6_DY        (-2)
`define SV_A6_AXIS      shell_volley_pkg::AXIS_Y
`define SV_A6_EDGE      90

`define SV_A7_X0        740
`define SV_A7_Y0        630
`define SV_A7_DX        (-1)
`define SV_A7_DY        (-2)
`define SV_A7_AXIS      shell_volley_pkg::AXIS_Y
`define SV_A7_EDGE      90

// launches 10 px further right than angle 1 and flies 400 ticks
`define SV_A8_X0        900
`define SV_A8_Y0        530
`define SV_A8_DX        (-2)
`define SV_A8_DY        (-1)
`define SV_A8_AXIS      shell_volley_pkg::AXIS_X
`define SV_A8_EDGE      100

`endif

// ==== logic/shell_volley_pkg.sv ====
`include "shell_volley_defines.svh"

package shell_volley_pkg;

    // ***********************************************************
    // screen and game types
    // ***********************************************************

    // one screen coordinate, x or y
    typedef logic [`SV_COORD_W-1:0] coord_t;

    // point count that wraps at 256
    typedef logic [`SV_SCORE_W-1:0] score_t;

    // angle selector
    // 1 to 8 select a shell and 0 or 9..15 select none
    typedef logic [`SV_ANGLE_W-1:0] angle_t;

    // one-hot state code from the game FSM
    typedef logic [`SV_STATE_W-1:0] game_state_t;

    // ***********************************************************
    // flight end axis
    // ***********************************************************

    // which coordinate is compared against the edge value
    typedef enum logic
    {
        AXIS_X = 1'b0,
        AXIS_Y = 1'b1
    } edge_axis_t;

endpackage

// ==== logic/shell_if.sv ====
`timescale 1ns/1ps

// one shell's view toward the scorer and the top outputs
interface shell_if;

    // shell is flying
    logic                       en;

    // current position
    shell_volley_pkg::coord_t   x;
    shell_volley_pkg::coord_t   y;

    // end-axis coordinate sits on the edge value
    logic                       arrive;

    // owned by the angle's track
    modport track
    (
        output en,
        output x,
        output y,
        output arrive
    );

    // scorer only needs the arrival flag
    modport score
    (
        input arrive
    );

endinterface

// ==== logic/shell_track.sv ====
`timescale 1ns/1ps
`include "shell_volley_defines.svh"

module shell_track
#(
    parameter int                           ANGLE_ID = 1,
    parameter shell_volley_pkg::coord_t     X0       = '0,
    parameter shell_volley_pkg::coord_t     Y0       = '0,
    parameter int                           DX       = 1,
    parameter int                           DY       = 1,
    parameter shell_volley_pkg::edge_axis_t AXIS     = shell_volley_pkg::AXIS_X,
    parameter shell_volley_pkg::coord_t     EDGE     = '0
)
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            tick,
    input  logic                            move_en,
    input  shell_volley_pkg::game_state_t   state,
    input  shell_volley_pkg::angle_t        angle,
    shell_if.track                          shell
);

    // ***********************************************************
    // local state and decode
    // ***********************************************************

    // step sizes as coordinate-wide two's complement
    localparam shell_volley_pkg::coord_t STEP_X = shell_volley_pkg::coord_t'(DX);
    localparam shell_volley_pkg::coord_t STEP_Y = shell_volley_pkg::coord_t'(DY);

    logic                       en_q;
    shell_volley_pkg::coord_t   x_q;
    shell_volley_pkg::coord_t   y_q;

    logic                       selected;
    logic                       playing;
    logic                       on_edge;

    // this angle is the one being aimed
    assign selected = (angle == shell_volley_pkg::angle_t'(ANGLE_ID));

    // stage allows flight at all
    assign playing  = move_en && (state == `SV_STATE_PLAY);

    // compare only the axis that ends the flight
    assign on_edge  = (AXIS == shell_volley_pkg::AXIS_X) ? (x_q == EDGE) : (y_q == EDGE);

    // ***********************************************************
    // enable flag
    // ***********************************************************

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            en_q <= 1'b0;
        end
        else if (tick)
        begin
            // play over or stage halted
            if (!playing)
            begin
                en_q <= 1'b0;
            end
            // aimed here so fire or keep flying
            else if (selected)
            begin
                en_q <= 1'b1;
            end
            // aim moved away so stop once the flight ends
            else if (on_edge)
            begin
                en_q <= 1'b0;
            end
        end
    end

    // ***********************************************************
    // position
    // ***********************************************************

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            x_q <= X0;
            y_q <= Y0;
        end
        else if (tick)
        begin
            if (move_en && en_q)
            begin
                // edge reached so back to launch
                if (on_edge)
                begin
                    x_q <= X0;
                    y_q <= Y0;
                end
                else
                begin
                    x_q <= x_q + STEP_X;
                    y_q <= y_q + STEP_Y;
                end
            end
            else
            begin
                // parked at launch while idle
                x_q <= X0;
                y_q <= Y0;
            end
        end
    end

    // out onto the bus
    assign shell.en     = en_q;
    assign shell.x      = x_q;
    assign shell.y      = y_q;
    assign shell.arrive = on_edge;

endmodule

// ==== logic/shot_score.sv ====
`timescale 1ns/1ps
`include "shell_volley_defines.svh"

module shot_score
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            tick,
    input  shell_volley_pkg::game_state_t   state,
    shell_if.score                          shells [`SV_NUM_ANGLES],
    output shell_volley_pkg::score_t        score
);

    // ***********************************************************
    // arrival collection
    // ***********************************************************

    logic [`SV_NUM_ANGLES-1:0]  arrive_vec;
    logic                       any_arrive;

    // gather the arrival flag of every angle
    for (genvar i = 0; i < `SV_NUM_ANGLES; i++)
    begin : g_arrive
        assign arrive_vec[i] = shells[i].arrive;
    end

    // several shells on the same tick still count once
    assign any_arrive = |arrive_vec;

    // ***********************************************************
    // point counter
    // ***********************************************************

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            score <= '0;
        end
        else if (tick)
        begin
            // new game starts from zero
            if (state == `SV_STATE_IDLE)
            begin
                score <= '0;
            end
            // free-running wrap at 256
            else if (any_arrive)
            begin
                score <= score + 1'b1;
            end
        end
    end

endmodule

// ==== logic/shell_volley.sv ====
`timescale 1ns/1ps
`include "shell_volley_defines.svh"

module shell_volley
(
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                tick,
    input  logic                                                move_en,
    input  shell_volley_pkg::game_state_t                       state,
    input  shell_volley_pkg::angle_t                            angle,
    output logic [`SV_NUM_ANGLES-1:0]                           shell_en,
    output shell_volley_pkg::coord_t [`SV_NUM_ANGLES-1:0]       shell_x,
    output shell_volley_pkg::coord_t [`SV_NUM_ANGLES-1:0]       shell_y,
    output shell_volley_pkg::score_t                            score
);

    // one bus per angle with index n-1 for angle n
    shell_if shell_bus [`SV_NUM_ANGLES] ();

    // ***********************************************************
    // per-angle tracks
    // ***********************************************************

    for (genvar g = 0; g < `SV_NUM_ANGLES; g++)
    begin : g_angle
        // pick the flight constants for angle g+1
        case (g + 1)
            1:
            begin : g_a1
                shell_track #(.ANGLE_ID(1), .X0(`SV_A1_X0), .Y0(`SV_A1_Y0),
                    .DX(`SV_A1_DX), .DY(`SV_A1_DY), .AXIS(`SV_A1_AXIS), .EDGE(`SV_A1_EDGE))
                u_track (.clk(clk), .rst_n(rst_n), .tick(tick), .move_en(move_en),
                    .state(state), .angle(angle), .shell(shell_bus[g]));
            end
            2:
            begin : g_a2
                shell_track #(.ANGLE_ID(2), .X0(`SV_A2_X0), .Y0(`SV_A2_Y0),
                    .DX(`SV_A2_DX), .DY(`SV_A2_DY), .AXIS(`SV_A2_AXIS), .EDGE(`SV_A2_EDGE))
                u_track (.clk(clk), .rst_n(rst_n), .tick(tick), .move_en(move_en),
                    .state(state), .angle(angle), .shell(shell_bus[g]));
            end
            3:
            begin : g_a3
                shell_track #(.ANGLE_ID(3), .X0(`SV_A3_X0), .Y0(`SV_A3_Y0),
                    .DX(`SV_A3_DX), .DY(`SV_A3_DY), .AXIS(`SV_A3_AXIS), .EDGE(`SV_A3_EDGE))
                u_track (.clk(clk), .rst_n(rst_n), .tick(tick), .move_en(move_en),
                    .state(state), .angle(angle), .shell(shell_bus[g]));
            end
            4:
            begin : g_a4
                shell_track #(.ANGLE_ID(4), .X0(`SV_A4_X0), .Y0(`SV_A4_Y0),
                    .DX(`SV_A4_DX), .DY(`SV_A4_DY), .AXIS(`SV_A4_AXIS), .EDGE(`SV_A4_EDGE))
                u_track (.clk(clk), .rst_n(rst_n), .tick(tick), .move_en(move_en),
                    .state(state), .angle(angle), .shell(shell_bus[g]));
            end
            5:
            begin : g_a5
                shell_track #(.ANGLE_ID(5), .X0(`SV_A5_X0), .Y0(`SV_A5_Y0),
                    .DX(`SV_A5_DX), .DY(`SV_A5_DY), .AXIS(`SV_A5_AXIS), .EDGE(`SV_A5_EDGE))
                u_track (.clk(clk), .rst_n(rst_n), .tick(tick), .move_en(move_en),
                    .state(state), .angle(angle), .shell(shell_bus[g]));
            end
            6:
            begin : g_a6
                shell_track #(.ANGLE_ID(6), .X0(`SV_A6_X0), .Y0(`SV_A6_Y0),
                    .DX(`SV_A6_DX), .DY(`SV_A6_DY), .AXIS(`SV_A6_AXIS), .EDGE(`SV_A6_EDGE))
                u_track (.clk(clk), .rst_n(rst_n), .tick(tick), .move_en(move_en),
                    .state(state), .angle(angle), .shell(shell_bus[g]));
            end
            7:
            begin : g_a7
                shell_track #(.ANGLE_ID(7), .X0(`SV_A7_X0), .Y0(`SV_A7_Y0),
                    .DX(`SV_A7_DX), .DY(`SV_A7_DY), .AXIS(`SV_A7_AXIS), .EDGE(`SV_A7_EDGE))
                u_track (.clk(clk), .rst_n(rst_n), .tick(tick), .move_en(move_en),
                    .state(state), .angle(angle), .shell(shell_bus[g]));
            end
            default:
            begin : g_a8
                shell_track #(.ANGLE_ID(8), .X0(`SV_A8_X0), .Y0(`SV_A8_Y0),
                    .DX(`SV_A8_DX), .DY(`SV_A8_DY), .AXIS(`SV_A8_AXIS), .EDGE(`SV_A8_EDGE))
                u_track (.clk(clk), .rst_n(rst_n), .tick(tick), .move_en(move_en),
                    .state(state), .angle(angle), .shell(shell_bus[g]));
            end
        endcase

        // flatten for the sprite renderer
        assign shell_en[g] = shell_bus[g].en;
        assign shell_x[g]  = shell_bus[g].x;
        assign shell_y[g]  = shell_bus[g].y;
    end

    // ***********************************************************
    // scoring
    // ***********************************************************

    shot_score u_score
    (
        .clk    (clk),
        .rst_n  (rst_n),
        .tick   (tick),
        .state  (state),
        .shells (shell_bus),
        .score  (score)
    );

endmodule

// ==== verif/tb_shell_volley.sv ====
`timescale 1ns/1ps
`include "shell_volley_defines.svh"

module tb_shell_volley;

    // ***********************************************************
    // dut signals and pattern storage
    // ***********************************************************

    logic                                           clk;
    logic                                           rst_n;
    logic                                           tick;
    logic                                           move_en;
    shell_volley_pkg::game_state_t                  state;
    shell_volley_pkg::angle_t                       angle;
    logic [`SV_NUM_ANGLES-1:0]                      shell_en;
    shell_volley_pkg::coord_t [`SV_NUM_ANGLES-1:0]  shell_x;
    shell_volley_pkg::coord_t [`SV_NUM_ANGLES-1:0]  shell_y;
    shell_volley_pkg::score_t                       score;

    // six words per phase as laid out in the pattern file
    localparam int MAX_PHASES = 32;
    logic [15:0] pat_mem [0:6*MAX_PHASES-1];

    // closing sweep that aims every angle in turn
    localparam int SWEEP_TICKS = 3;

    // flight geometry, index n-1 for angle n
    int                             x0     [`SV_NUM_ANGLES];
    int                             y0     [`SV_NUM_ANGLES];
    int                             dx     [`SV_NUM_ANGLES];
    int                             dy     [`SV_NUM_ANGLES];
    int                             edge_v [`SV_NUM_ANGLES];
    shell_volley_pkg::edge_axis_t   axis   [`SV_NUM_ANGLES];

    // reference model state
    int     mx  [`SV_NUM_ANGLES];
    int     my  [`SV_NUM_ANGLES];
    logic   men [`SV_NUM_ANGLES];
    int     mscore;

    shell_volley DUT
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .tick     (tick),
        .move_en  (move_en),
        .state    (state),
        .angle    (angle),
        .shell_en (shell_en),
        .shell_x  (shell_x),
        .shell_y  (shell_y),
        .score    (score)
    );

    // 4 ns clock
    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ***********************************************************
    // reference model
    // ***********************************************************

    task automatic set_angle(input int n, input int ax0, input int ay0, input int adx,
                             input int ady, input shell_volley_pkg::edge_axis_t aaxis,
                             input int aedge);
        x0[n-1]     = ax0;
        y0[n-1]     = ay0;
        dx[n-1]     = adx;
        dy[n-1]     = ady;
        axis[n-1]   = aaxis;
        edge_v[n-1] = aedge;
    endtask

    task automatic load_geometry();
        set_angle(1, `SV_A1_X0, `SV_A1_Y0, `SV_A1_DX, `SV_A1_DY, `SV_A1_AXIS, `SV_A1_EDGE);
        set_angle(2, `SV_A2_X0, `SV_A2_Y0, `SV_A2_DX, `SV_A2_DY, `SV_A2_AXIS, `SV_A2_EDGE);
        set_angle(3, `SV_A3_X0, `SV_A3_Y0, `SV_A3_DX, `SV_A3_DY, `SV_A3_AXIS, `SV_A3_EDGE);
        set_angle(4, `SV_A4_X0, `SV_A4_Y0, `SV_A4_DX, `SV_A4_DY, `SV_A4_AXIS, `SV_A4_EDGE);
        set_angle(5, `SV_A5_X0, `SV_A5_Y0, `SV_A5_DX, `SV_A5_DY, `SV_A5_AXIS, `SV_A5_EDGE);
        set_angle(6, `SV_A6_X0, `SV_A6_Y0, `SV_A6_DX, `SV_A6_DY, `SV_A6_AXIS, `SV_A6_EDGE);
        set_angle(7, `SV_A7_X0, `SV_A7_Y0, `SV_A7_DX, `SV_A7_DY, `SV_A7_AXIS, `SV_A7_EDGE);
        set_angle(8, `SV_A8_X0, `SV_A8_Y0, `SV_A8_DX, `SV_A8_DY, `SV_A8_AXIS, `SV_A8_EDGE);
    endtask

    // all shells parked and nothing scored
    task automatic model_reset();
        for (int i = 0; i < `SV_NUM_ANGLES; i++)
        begin
            men[i] = 1'b0;
            mx[i]  = x0[i];
            my[i]  = y0[i];
        end
        mscore = 0;
    endtask

    // one tick decided from the values before it
    task automatic model_tick();
        logic arrive [`SV_NUM_ANGLES];
        logic any_arrive;
        logic playing;
        playing    = move_en && (state == `SV_STATE_PLAY);
        any_arrive = 1'b0;
        for (int i = 0; i < `SV_NUM_ANGLES; i++)
        begin
            if (axis[i] == shell_volley_pkg::AXIS_X)
                arrive[i] = (mx[i] == edge_v[i]);
            else
                arrive[i] = (my[i] == edge_v[i]);
            any_arrive = any_arrive | arrive[i];
        end
        for (int i = 0; i < `SV_NUM_ANGLES; i++)
        begin
            // position uses the enable from before the tick
            if (move_en && men[i] && !arrive[i])
            begin
                mx[i] = mx[i] + dx[i];
                my[i] = my[i] + dy[i];
            end
            else
            begin
                mx[i] = x0[i];
                my[i] = y0[i];
            end
            if (!playing)
                men[i] = 1'b0;
            else if (angle == i + 1)
                men[i] = 1'b1;
            else if (arrive[i])
                men[i] = 1'b0;
        end
        // one point per tick however many shells land
        if (state == `SV_STATE_IDLE)
            mscore = 0;
        else if (any_arrive)
            mscore = (mscore + 1) % 256;
    endtask

    // ***********************************************************
    // compare tasks
    // ***********************************************************

    task automatic check_en(input logic [`SV_NUM_ANGLES-1:0] got,
                            input logic [`SV_NUM_ANGLES-1:0] exp, input string name);
        if (got !== exp)
        begin
            $display("Mismatch %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "enable mask wrong");
        end
    endtask

    task automatic check_coord(input shell_volley_pkg::coord_t got,
                               input shell_volley_pkg::coord_t exp, input string name);
        if (got !== exp)
        begin
            $display("Mismatch %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "coordinate wrong");
        end
    endtask

    task automatic check_score(input shell_volley_pkg::score_t got,
                               input shell_volley_pkg::score_t exp, input string name);
        if (got !== exp)
        begin
            $display("Mismatch %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "score wrong");
        end
    endtask

    // every output against the model
    task automatic check_all();
        logic [`SV_NUM_ANGLES-1:0] exp_en;
        for (int i = 0; i < `SV_NUM_ANGLES; i++)
            exp_en[i] = men[i];
        check_en(shell_en, exp_en, "shell_en");
        for (int i = 0; i < `SV_NUM_ANGLES; i++)
        begin
            check_coord(shell_x[i], shell_volley_pkg::coord_t'(mx[i]),
                        $sformatf("shell_x[%0d]", i));
            check_coord(shell_y[i], shell_volley_pkg::coord_t'(my[i]),
                        $sformatf("shell_y[%0d]", i));
        end
        check_score(score, shell_volley_pkg::score_t'(mscore), "score");
    endtask

    // ***********************************************************
    // stimulus
    // ***********************************************************

    // random gap followed by a one-clk tick strobe
    task automatic pulse_tick();
        int gap;
        gap = $urandom_range(4, 1);
        repeat (gap) @(negedge clk);
        // gap clocks must not move anything
        check_all();
        tick = 1'b1;
        @(negedge clk);
        tick = 1'b0;
        model_tick();
        check_all();
    endtask

    task automatic watchdog(input longint limit_ns);
        #(limit_ns);
        $display("Timeout: run did not finish within %0d ns", limit_ns);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    endtask

    initial
    begin
        int     n_phases;
        int     total_ticks;
        int     base;
        longint limit_ns;
        void'($urandom(69));
        rst_n   = 1'b0;
        tick    = 1'b0;
        move_en = 1'b0;
        state   = `SV_STATE_IDLE;
        angle   = '0;
        load_geometry();
        model_reset();
        $readmemh("verif/shell_volley_patterns.txt", pat_mem);

        // phases up to the end marker
        n_phases    = 0;
        total_ticks = 0;
        while (n_phases < MAX_PHASES && !$isunknown(pat_mem[6*n_phases])
               && pat_mem[6*n_phases] != 16'hffff)
        begin
            total_ticks = total_ticks + pat_mem[6*n_phases+3];
            n_phases++;
        end
        if (n_phases == 0)
        begin
            $display("No phases could be read from the pattern file");
            $display("CHECKS FAILED");
            $fatal(1, "empty pattern file");
        end
        total_ticks = total_ticks + SWEEP_TICKS * `SV_NUM_ANGLES;

        // up to 5 clks per tick plus reset and then doubled
        limit_ns = (longint'(total_ticks) * 5 + 20) * 4 * 2;
        fork
            watchdog(limit_ns);
        join_none

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_all();

        for (int p = 0; p < n_phases; p++)
        begin
            base    = 6 * p;
            state   = pat_mem[base][`SV_STATE_W-1:0];
            angle   = pat_mem[base+1][`SV_ANGLE_W-1:0];
            move_en = pat_mem[base+2][0];
            repeat (pat_mem[base+3]) pulse_tick();
            // phase end against the file
            check_en(shell_en, pat_mem[base+4][`SV_NUM_ANGLES-1:0],
                     $sformatf("shell_en at end of phase %0d", p));
            check_score(score, pat_mem[base+5][`SV_SCORE_W-1:0],
                        $sformatf("score at end of phase %0d", p));
        end

        // each angle aimed in play so every track leaves launch
        state   = `SV_STATE_PLAY;
        move_en = 1'b1;
        for (int n = 1; n <= `SV_NUM_ANGLES; n++)
        begin
            angle = shell_volley_pkg::angle_t'(n);
            repeat (SWEEP_TICKS) pulse_tick();
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== verif/shell_volley_patterns.txt ====
// columns, all hex: state angle move_en ticks mask score
// mask and score are expected at the end of the phase
01 0 0 0005 00 00
01 2 1 0003 00 00
// angle 2 full flight, lands on tick 272
08 2 1 0118 02 01
// angle 8 joins while shell 2 flies on
08 8 1 0005 82 01
// angle 1 five ticks later, shells 8 and 1 land together
08 1 1 0190 01 03
// move enable dropped
08 1 0 0003 00 03
08 5 1 0014 10 03
// some other game state
10 5 1 0003 00 03
01 5 1 0003 00 00
08 6 1 000c 20 00
08 0 1 000c 20 00
08 4 1 000a 28 00
08 3 1 0006 2c 00
// end marker
ffff 0 0 0 0 0

// ==== shell_volley.f ====
+incdir+logic
logic/shell_volley_pkg.sv
logic/shell_if.sv
logic/shell_track.sv
logic/shot_score.sv
logic/shell_volley.sv
verif/tb_shell_volley.sv

// ==== Bender.yml ====
package:
  name: shell_volley

sources:
  - include_dirs:
      - logic
    files:
      - logic/shell_volley_pkg.sv
      - logic/shell_if.sv
      - logic/shell_track.sv
      - logic/shot_score.sv
      - logic/shell_volley.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/tb_shell_volley.sv
